//--- cam_capture.sv
`timescale 1ns/1ps
// camera pixel capture, pclk domain
// frame gating on config done, vsync edges, rgb565 byte pairs to rgb444

module cam_capture (
    input  logic                                i_cam_pclk,
    input  logic                                i_rst_n,
    input  logic                                i_cfg_done,   // cfg clock domain
    input  logic                                i_cam_vsync,  // high in blanking
    input  logic                                i_cam_href,   // high on valid bytes
    input  logic [cam_pix_pkg::PIX_IN_W-1:0]    i_cam_data,
    output logic                                o_buf_wr,
    output logic [cam_pix_pkg::PIX_OUT_W-1:0]   o_buf_wdata,
    output logic                                o_sof,
    output logic                                o_vsync_posedge,
    output logic                                o_vsync_negedge
);

    cam_pix_pkg::cap_state_e state;
    logic                             vsync_q;
    logic                             vsync_d;   // previous registered vsync
    logic                             href_q;
    logic [cam_pix_pkg::PIX_IN_W-1:0] data_q;
    logic [cam_pix_pkg::PIX_IN_W-1:0] first_q;   // first byte of the pair
    logic                             done_s1;
    logic                             done_s2;
    logic                             have_first;
    logic                             vs_rise;
    logic                             vs_fall;

    //------------------------------------------------------------
    // input register, done sync, edge pulses
    //------------------------------------------------------------
    always_ff @(posedge i_cam_pclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            vsync_q         <= 1'b0;
            vsync_d         <= 1'b0;
            href_q          <= 1'b0;
            done_s1         <= 1'b0;
            done_s2         <= 1'b0;
            o_vsync_posedge <= 1'b0;
            o_vsync_negedge <= 1'b0;
            o_sof           <= 1'b0;
        end else begin
            vsync_q         <= i_cam_vsync;
            vsync_d         <= vsync_q;
            href_q          <= i_cam_href;
            done_s1         <= i_cfg_done;   // two-flop sync
            done_s2         <= done_s1;
            o_vsync_posedge <= vs_rise;
            o_vsync_negedge <= vs_fall;
            o_sof           <= vs_fall && (state == cam_pix_pkg::CAP_ARMED);
        end
    end

    assign vs_rise = vsync_q & ~vsync_d;
    assign vs_fall = ~vsync_q & vsync_d;

    // frame gating
    always_ff @(posedge i_cam_pclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= cam_pix_pkg::CAP_WAIT_CFG;
        end else begin
            unique case (state)
                cam_pix_pkg::CAP_WAIT_CFG: begin
                    if (done_s2) state <= cam_pix_pkg::CAP_ARMED;
                end
                cam_pix_pkg::CAP_ARMED: begin
                    if (!done_s2) state <= cam_pix_pkg::CAP_WAIT_CFG;  // re-init
                    else if (vs_fall) state <= cam_pix_pkg::CAP_FRAME;
                end
                cam_pix_pkg::CAP_FRAME: begin
                    if (vs_rise) begin  // frame over
                        state <= done_s2 ? cam_pix_pkg::CAP_ARMED : cam_pix_pkg::CAP_WAIT_CFG;
                    end
                end
                default: state <= cam_pix_pkg::CAP_WAIT_CFG;
            endcase
        end
    end

    //------------------------------------------------------------
    // byte pairing, restarts with every href high run
    //------------------------------------------------------------
    always_ff @(posedge i_cam_pclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            have_first <= 1'b0;
            o_buf_wr   <= 1'b0;
        end else begin
            o_buf_wr <= 1'b0;
            if (state != cam_pix_pkg::CAP_FRAME || !href_q) begin
                have_first <= 1'b0;  // orphan byte dropped here
            end else if (!have_first) begin
                have_first <= 1'b1;
            end else begin
                have_first <= 1'b0;
                o_buf_wr   <= 1'b1;  // pair complete
            end
        end
    end

    always_ff @(posedge i_cam_pclk) begin
        data_q <= i_cam_data;
        if (!have_first) first_q <= data_q;
        // r[4:1], g[5:2], b[4:1]
        o_buf_wdata <= {first_q[7:4], first_q[2:0], data_q[7], data_q[4:1]};
    end

endmodule

//--- cam_cfg.sv
`timescale 1ns/1ps
// camera configuration sequencer
// walks the register table, one SCCB write per entry, busy/done flags

module cam_cfg (
    input  logic i_cfg_clk,
    input  logic i_rst_n,
    input  logic i_cfg_init,   // one-cycle start, ignored while busy
    input  logic i_scl,
    output logic o_scl,
    output logic o_sda,
    output logic o_cfg_busy,
    output logic o_cfg_done
);

    cam_sccb_pkg::cfg_state_e state;
    logic [cam_sccb_pkg::ROM_AW-1:0] index;  // current table entry
    logic [7:0] reg_addr;
    logic [7:0] reg_data;
    logic       sb_start;
    logic       sb_done;

    cam_reg_rom u_rom (
        .i_index    (index),
        .o_reg_addr (reg_addr),
        .o_reg_data (reg_data)
    );

    sccb_master u_sccb (
        .i_cfg_clk  (i_cfg_clk),
        .i_rst_n    (i_rst_n),
        .i_start    (sb_start),
        .i_reg_addr (reg_addr),
        .i_reg_data (reg_data),
        .i_scl      (i_scl),
        .o_scl      (o_scl),
        .o_sda      (o_sda),
        .o_done     (sb_done)
    );

    assign sb_start = (state == cam_sccb_pkg::CFG_ISSUE);  // one cycle per entry

    always_ff @(posedge i_cfg_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= cam_sccb_pkg::CFG_IDLE;
            index <= '0;
        end else begin
            unique case (state)
                cam_sccb_pkg::CFG_IDLE, cam_sccb_pkg::CFG_DONE: begin
                    if (i_cfg_init) begin
                        index <= '0;
                        state <= cam_sccb_pkg::CFG_ISSUE;  // clears done
                    end
                end
                cam_sccb_pkg::CFG_ISSUE: state <= cam_sccb_pkg::CFG_WAIT;
                cam_sccb_pkg::CFG_WAIT: begin
                    if (sb_done) begin
                        if (index == cam_sccb_pkg::ROM_AW'(cam_sccb_pkg::ROM_DEPTH - 1)) begin
                            state <= cam_sccb_pkg::CFG_DONE;
                        end else begin
                            index <= index + 1'b1;
                            state <= cam_sccb_pkg::CFG_ISSUE;
                        end
                    end
                end
            endcase
        end
    end

    // flags decoded straight from the state
    assign o_cfg_busy = (state == cam_sccb_pkg::CFG_ISSUE) || (state == cam_sccb_pkg::CFG_WAIT);
    assign o_cfg_done = (state == cam_sccb_pkg::CFG_DONE);

endmodule

//--- cam_pix_pkg.sv
// pixel capture constants
// byte width from the camera, RGB444 word width, capture states

package cam_pix_pkg;

    localparam int PIX_IN_W  = 8;   // camera data bus
    localparam int PIX_OUT_W = 12;  // rgb444 to the fifo

    // frame gating
    typedef enum logic [1:0] {
        CAP_WAIT_CFG,  // config not done yet
        CAP_ARMED,     // waiting for vsync to fall
        CAP_FRAME      // capturing rows
    } cap_state_e;

endpackage

//--- cam_reg_rom.sv
`timescale 1ns/1ps
// camera register table
// address/value pairs written in order after init

module cam_reg_rom (
    input  logic [cam_sccb_pkg::ROM_AW-1:0] i_index,
    output logic [7:0]                      o_reg_addr,
    output logic [7:0]                      o_reg_data
);

    logic [15:0] entry;  // {addr, value}

    always_comb begin
        case (i_index)
            3'd0:    entry = {8'h12, 8'h80};  // COM7 soft reset
            3'd1:    entry = {8'h12, 8'h04};  // COM7 rgb output
            3'd2:    entry = {8'h40, 8'hD0};  // COM15 rgb565, full range
            3'd3:    entry = {8'h8C, 8'h00};  // RGB444 off
            3'd4:    entry = {8'h11, 8'h01};  // CLKRC prescale
            default: entry = {8'h3A, 8'h04};  // TSLB, last entry and out of range
        endcase
    end

    assign o_reg_addr = entry[15:8];
    assign o_reg_data = entry[7:0];

endmodule

//--- cam_sccb_pkg.sv
// camera configuration constants
// SCCB bit timing, camera write address, register table size
// and the FSM state types of the configuration side

package cam_sccb_pkg;

    //------------------------------------------------------------
    // SCCB timing and addressing
    //------------------------------------------------------------
    localparam int CFG_CLK_DIV = 8;             // cfg clocks per quarter bit
    localparam logic [7:0] SCCB_DEV_ADDR = 8'h42; // OV7670 write address

    //------------------------------------------------------------
    // register table
    //------------------------------------------------------------
    localparam int ROM_DEPTH = 6;  // address/value pairs
    localparam int ROM_AW    = 3;  // index width

    // sequencer over the table
    typedef enum logic [1:0] {
        CFG_IDLE,   // waiting for init
        CFG_ISSUE,  // start pulse to the master
        CFG_WAIT,   // write in flight
        CFG_DONE    // table loaded
    } cfg_state_e;

    // single write on the bus
    typedef enum logic [1:0] {
        SB_IDLE,
        SB_START,
        SB_BIT,     // 27 slots, 3 bytes x (8 data + don't-care)
        SB_STOP
    } sccb_state_e;

endpackage

//--- cam_top.f
cam_sccb_pkg.sv
cam_pix_pkg.sv
cam_reg_rom.sv
sccb_master.sv
cam_cfg.sv
cam_capture.sv
cam_top.sv
tb_cam_top.sv

//--- cam_top.sv
`timescale 1ns/1ps
// camera front end
// SCCB register loader in the cfg domain, pixel capture in the pclk domain

module cam_top (
    input  logic                                i_cfg_clk,
    input  logic                                i_cam_pclk,
    input  logic                                i_rst_n,
    input  logic                                i_cfg_init,   // load the register table
    input  logic                                i_cam_vsync,
    input  logic                                i_cam_href,
    input  logic [cam_pix_pkg::PIX_IN_W-1:0]    i_cam_data,
    input  logic                                i_scl,        // resolved bus levels
    input  logic                                i_sda,        // ack is don't-care, unread
    output logic                                o_scl,        // 1 = released
    output logic                                o_sda,
    output logic                                o_cfg_done,
    output logic                                o_cfg_busy,
    output logic                                o_buf_wr,     // to the pixel fifo
    output logic [cam_pix_pkg::PIX_OUT_W-1:0]   o_buf_wdata,
    output logic                                o_sof,
    output logic                                o_vsync_posedge,
    output logic                                o_vsync_negedge
);

    //------------------------------------------------------------
    // register loader, cfg clock
    //------------------------------------------------------------
    cam_cfg u_cfg (
        .i_cfg_clk  (i_cfg_clk),
        .i_rst_n    (i_rst_n),
        .i_cfg_init (i_cfg_init),
        .i_scl      (i_scl),
        .o_scl      (o_scl),
        .o_sda      (o_sda),
        .o_cfg_busy (o_cfg_busy),
        .o_cfg_done (o_cfg_done)
    );

    //------------------------------------------------------------
    // capture, pclk, done crosses inside
    //------------------------------------------------------------
    cam_capture u_capture (
        .i_cam_pclk      (i_cam_pclk),
        .i_rst_n         (i_rst_n),
        .i_cfg_done      (o_cfg_done),
        .i_cam_vsync     (i_cam_vsync),
        .i_cam_href      (i_cam_href),
        .i_cam_data      (i_cam_data),
        .o_buf_wr        (o_buf_wr),
        .o_buf_wdata     (o_buf_wdata),
        .o_sof           (o_sof),
        .o_vsync_posedge (o_vsync_posedge),
        .o_vsync_negedge (o_vsync_negedge)
    );

endmodule

//--- sccb_master.sv
`timescale 1ns/1ps
// SCCB write master
// START, device address, register address, value, STOP on open-drain
// scl/sda; a slave holding scl low stretches the high phase

module sccb_master (
    input  logic       i_cfg_clk,
    input  logic       i_rst_n,
    input  logic       i_start,     // one cycle, latches both bytes
    input  logic [7:0] i_reg_addr,
    input  logic [7:0] i_reg_data,
    input  logic       i_scl,       // resolved scl level
    output logic       o_scl,       // 1 = released
    output logic       o_sda,       // 1 = released
    output logic       o_done       // one cycle, after stop
);

    localparam int DIV_W = $clog2(cam_sccb_pkg::CFG_CLK_DIV);

    cam_sccb_pkg::sccb_state_e state;
    logic [DIV_W-1:0] div;       // quarter-bit divider
    logic [1:0]       quarter;   // 0,1 scl low  2,3 scl high
    logic [3:0]       bit_cnt;   // 0..7 data, 8 don't-care
    logic [1:0]       byte_cnt;
    logic [23:0]      shift_q;   // msb goes out first
    logic             stall;
    logic             tick;

    // scl released but still low, slave is stretching
    assign stall = (state == cam_sccb_pkg::SB_BIT || state == cam_sccb_pkg::SB_STOP)
                   && (quarter == 2'd2) && !i_scl;
    assign tick  = (div == DIV_W'(cam_sccb_pkg::CFG_CLK_DIV - 1)) && !stall;

    //------------------------------------------------------------
    // quarter-bit divider, frozen while stretched
    //------------------------------------------------------------
    always_ff @(posedge i_cfg_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            div <= '0;
        end else if (state == cam_sccb_pkg::SB_IDLE || tick) begin
            div <= '0;
        end else if (!stall) begin
            div <= div + 1'b1;
        end
    end

    // payload shifter
    always_ff @(posedge i_cfg_clk) begin
        if (state == cam_sccb_pkg::SB_IDLE && i_start) begin
            shift_q <= {cam_sccb_pkg::SCCB_DEV_ADDR, i_reg_addr, i_reg_data};
        end else if (state == cam_sccb_pkg::SB_BIT && tick && quarter == 2'd3
                     && bit_cnt != 4'd8) begin
            shift_q <= {shift_q[22:0], 1'b0};
        end
    end

    //------------------------------------------------------------
    // bus FSM, sda only moves in the middle of the low phase
    //------------------------------------------------------------
    always_ff @(posedge i_cfg_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state    <= cam_sccb_pkg::SB_IDLE;
            quarter  <= '0;
            bit_cnt  <= '0;
            byte_cnt <= '0;
            o_scl    <= 1'b1;
            o_sda    <= 1'b1;
            o_done   <= 1'b0;
        end else begin
            o_done <= 1'b0;
            unique case (state)
                cam_sccb_pkg::SB_IDLE: begin
                    quarter  <= '0;
                    bit_cnt  <= '0;
                    byte_cnt <= '0;
                    if (i_start) begin
                        o_sda <= 1'b0;  // start, sda falls with scl high
                        state <= cam_sccb_pkg::SB_START;
                    end
                end
                cam_sccb_pkg::SB_START: begin
                    if (tick) begin
                        o_scl <= 1'b0;  // hold time done, first low phase
                        state <= cam_sccb_pkg::SB_BIT;
                    end
                end
                cam_sccb_pkg::SB_BIT: begin
                    if (tick) begin
                        quarter <= quarter + 1'b1;
                        case (quarter)
                            2'd0: o_sda <= (bit_cnt == 4'd8) ? 1'b1 : shift_q[23];
                            2'd1: o_scl <= 1'b1;  // release, then wait for the line
                            2'd3: begin
                                o_scl <= 1'b0;
                                if (bit_cnt == 4'd8) begin
                                    bit_cnt  <= '0;
                                    byte_cnt <= byte_cnt + 1'b1;
                                    if (byte_cnt == 2'd2) begin
                                        state <= cam_sccb_pkg::SB_STOP;
                                    end
                                end else begin
                                    bit_cnt <= bit_cnt + 1'b1;
                                end
                            end
                            default: ;  // high phase, nothing moves
                        endcase
                    end
                end
                cam_sccb_pkg::SB_STOP: begin
                    if (tick) begin
                        quarter <= quarter + 1'b1;
                        case (quarter)
                            2'd0: o_sda <= 1'b0;   // low before stop
                            2'd1: o_scl <= 1'b1;
                            2'd2: o_sda <= 1'b1;   // stop, sda rises with scl high
                            default: begin
                                o_done <= 1'b1;    // bus free time elapsed
                                state  <= cam_sccb_pkg::SB_IDLE;
                            end
                        endcase
                    end
                end
            endcase
        end
    end

endmodule

//--- tb_cam_top.sv
`timescale 1ns/1ps
// camera front end testbench
// SCCB slave bus model with clock stretching, frame generator,
// register table and rgb565 to rgb444 reference checks

module tb_cam_top;

    localparam int DIV         = cam_sccb_pkg::CFG_CLK_DIV;
    localparam int TIMEOUT_CYC = 40000;  // 2 runs x 6 writes x ~900 cycles, frames, margin
    localparam int STRETCH_TXN = 8;      // third write of the second run
    localparam int STRETCH_BIT = 12;     // fourth bit of the register address byte
    localparam int STRETCH_CYC = 40;

    logic        i_cfg_clk;
    logic        i_cam_pclk;
    logic        i_rst_n;
    logic        i_cfg_init;
    logic        i_cam_vsync;
    logic        i_cam_href;
    logic [7:0]  i_cam_data;
    logic        o_scl;
    logic        o_sda;
    logic        o_cfg_done;
    logic        o_cfg_busy;
    logic        o_buf_wr;
    logic [11:0] o_buf_wdata;
    logic        o_sof;
    logic        o_vsync_posedge;
    logic        o_vsync_negedge;

    logic        slave_scl_rel = 1'b1;  // slave side of the open-drain bus
    logic        slave_sda_rel = 1'b1;  // ack is don't-care, never driven
    wire         scl_line = o_scl & slave_scl_rel;
    wire         sda_line = o_sda & slave_sda_rel;

    int          err_cnt = 0;
    int          chk_cnt = 0;
    int          cyc_cnt = 0;
    logic [31:0] rng_state = 32'd75867;

    // bus monitor state
    logic        prev_scl = 1'b1;
    logic        prev_sda = 1'b1;
    logic        in_txn = 1'b0;
    logic        high_timed = 1'b0;
    int          high_cnt = 0;
    int          nbits = 0;
    int          txn_cnt = 0;
    logic [26:0] bits_sr;
    int          stretch_left = 0;
    logic        stretch_seen = 1'b0;

    // handshake and capture monitors
    logic        busy_d = 1'b0;
    logic        done_d = 1'b0;
    logic        init_d = 1'b0;
    int          pos_cnt = 0;
    int          neg_cnt = 0;
    int          sof_cnt = 0;
    int          wr_cnt = 0;
    logic [11:0] exp_q[$];

    cam_top DUT (
        .i_cfg_clk(i_cfg_clk), .i_cam_pclk(i_cam_pclk), .i_rst_n(i_rst_n),
        .i_cfg_init(i_cfg_init), .i_cam_vsync(i_cam_vsync), .i_cam_href(i_cam_href),
        .i_cam_data(i_cam_data), .i_scl(scl_line), .i_sda(sda_line),
        .o_scl(o_scl), .o_sda(o_sda), .o_cfg_done(o_cfg_done), .o_cfg_busy(o_cfg_busy),
        .o_buf_wr(o_buf_wr), .o_buf_wdata(o_buf_wdata), .o_sof(o_sof),
        .o_vsync_posedge(o_vsync_posedge), .o_vsync_negedge(o_vsync_negedge)
    );

    always #5 i_cfg_clk = ~i_cfg_clk;    // 10 ns
    always #7 i_cam_pclk = ~i_cam_pclk;  // 14 ns, unrelated to cfg

    //------------------------------------------------------------
    // reference models and check helpers
    //------------------------------------------------------------
    function automatic logic [15:0] rom_entry(input int idx);
        case (idx)
            0:       rom_entry = 16'h1280;
            1:       rom_entry = 16'h1204;
            2:       rom_entry = 16'h40D0;
            3:       rom_entry = 16'h8C00;
            4:       rom_entry = 16'h1101;
            default: rom_entry = 16'h3A04;
        endcase
    endfunction

    function automatic logic [11:0] rgb565_to_444(input logic [7:0] b0, input logic [7:0] b1);
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
        r = b0[7:3];
        g = {b0[2:0], b1[7:5]};  // g split over both bytes
        b = b1[4:0];
        return {r[4:1], g[5:2], b[4:1]};
    endfunction

    function automatic logic [7:0] next_random_byte();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state[23:16];
    endfunction

    task automatic report_failure(input string msg);
        err_cnt++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    task automatic expect_equal(input string name, input logic [31:0] exp_v,
                                input logic [31:0] act_v);
        chk_cnt++;
        assert (exp_v === act_v) else begin
            err_cnt++;
            $display("Mismatch at %0t ns: %s expected %0h got %0h", $time, name, exp_v, act_v);
        end
    endtask

    task automatic check_idle_outputs();
        expect_equal("o_scl", 1, o_scl);
        expect_equal("o_sda", 1, o_sda);
        expect_equal("o_cfg_busy", 0, o_cfg_busy);
        expect_equal("o_cfg_done", 0, o_cfg_done);
        expect_equal("o_buf_wr", 0, o_buf_wr);
        expect_equal("o_sof", 0, o_sof);
        expect_equal("o_vsync_posedge", 0, o_vsync_posedge);
        expect_equal("o_vsync_negedge", 0, o_vsync_negedge);
    endtask

    // compare a finished write with the table
    task automatic check_transaction();
        logic [15:0] entry;
        entry = rom_entry(txn_cnt % cam_sccb_pkg::ROM_DEPTH);
        expect_equal("sccb bit count", 27, nbits);
        expect_equal("sccb device address", cam_sccb_pkg::SCCB_DEV_ADDR, bits_sr[26:19]);
        expect_equal("sccb register address", entry[15:8], bits_sr[17:10]);
        expect_equal("sccb register value", entry[7:0], bits_sr[8:1]);
    endtask

    //------------------------------------------------------------
    // SCCB slave, decodes on scl rise, times each high phase
    //------------------------------------------------------------
    always @(posedge i_cfg_clk) begin
        if (i_rst_n) begin
            if (prev_scl && scl_line && prev_sda && !sda_line) begin  // start
                if (in_txn) report_failure("SDA fell while SCL was high inside a write");
                in_txn     = 1'b1;
                nbits      = 0;
                high_timed = 1'b0;
            end else if (in_txn && prev_scl && scl_line && !prev_sda && sda_line) begin
                check_transaction();  // stop
                in_txn     = 1'b0;
                high_timed = 1'b0;
                txn_cnt++;
            end
            if (in_txn && !prev_scl && scl_line) begin
                if (nbits < 27) begin
                    bits_sr = {bits_sr[25:0], sda_line};
                    nbits++;
                end
                high_timed = 1'b1;
                high_cnt   = 1;
            end else if (scl_line && high_timed) begin
                high_cnt++;
            end else if (!scl_line && prev_scl && high_timed) begin
                expect_equal("scl high cycles", 2 * DIV, high_cnt);
                high_timed = 1'b0;
            end
            prev_scl = scl_line;
            prev_sda = sda_line;
        end
    end

    // hold scl low through one low phase of the chosen bit
    always @(negedge i_cfg_clk) begin
        if (stretch_left > 0) begin
            stretch_left = stretch_left - 1;
            if (stretch_left == 0) slave_scl_rel = 1'b1;
        end else if (!stretch_seen && in_txn && txn_cnt == STRETCH_TXN
                     && nbits == STRETCH_BIT && !scl_line) begin
            slave_scl_rel = 1'b0;
            stretch_left  = STRETCH_CYC;
            stretch_seen  = 1'b1;
        end
    end

    // busy/done handshake rules, flags sampled before the edge updates them
    always @(posedge i_cfg_clk) begin
        if (i_rst_n) begin
            if (!busy_d && o_cfg_busy) begin
                assert (init_d) else report_failure("busy rose without an init pulse");
            end
            if (busy_d && !o_cfg_busy) begin
                assert (o_cfg_done) else report_failure("busy fell before done rose");
            end
            if (done_d && !o_cfg_done) begin
                assert (init_d) else report_failure("done fell without an init pulse");
            end
            assert (!(o_cfg_busy && o_cfg_done)) else report_failure("busy and done both high");
        end
        busy_d = o_cfg_busy;
        done_d = o_cfg_done;
        init_d = i_cfg_init;
    end

    //------------------------------------------------------------
    // capture monitor, pclk domain
    //------------------------------------------------------------
    always @(posedge i_cam_pclk) begin
        if (i_rst_n) begin
            if (o_vsync_posedge) pos_cnt++;
            if (o_vsync_negedge) neg_cnt++;
            if (o_sof) begin
                sof_cnt++;
                assert (o_vsync_negedge) else report_failure("o_sof without o_vsync_negedge");
            end
            if (o_buf_wr) begin
                wr_cnt++;
                if (exp_q.size() == 0) report_failure("pixel write with no byte pair pending");
                else expect_equal("o_buf_wdata", exp_q.pop_front(), o_buf_wdata);
            end
        end
    end

    always @(posedge i_cfg_clk) begin
        cyc_cnt++;
        if (cyc_cnt >= TIMEOUT_CYC) begin
            report_failure("run did not finish within the cycle limit");
            $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic pulse_init(input bit accepted);
        @(negedge i_cfg_clk);
        i_cfg_init = 1'b1;
        @(negedge i_cfg_clk);
        i_cfg_init = 1'b0;
        expect_equal("o_cfg_busy", 1, o_cfg_busy);
        if (accepted) expect_equal("o_cfg_done", 0, o_cfg_done);
    endtask

    task automatic wait_cfg_done();
        while (!o_cfg_done) @(negedge i_cfg_clk);
    endtask

    // vsync pulse, then 4 rows of 6 pixels; odd_row gets a trailing byte
    task automatic send_frame(input bit captured, input int odd_row);
        int         pos0;
        int         neg0;
        int         sof0;
        int         wr0;
        logic [7:0] b0;
        logic [7:0] b1;
        pos0 = pos_cnt;
        neg0 = neg_cnt;
        sof0 = sof_cnt;
        wr0  = wr_cnt;
        @(negedge i_cam_pclk);
        i_cam_vsync = 1'b1;
        repeat (4) @(negedge i_cam_pclk);
        i_cam_vsync = 1'b0;
        repeat (4) @(negedge i_cam_pclk);
        for (int r = 0; r < 4; r++) begin
            i_cam_href = 1'b1;
            for (int p = 0; p < 6; p++) begin
                b0 = next_random_byte();
                i_cam_data = b0;
                @(negedge i_cam_pclk);
                b1 = next_random_byte();
                i_cam_data = b1;
                if (captured) exp_q.push_back(rgb565_to_444(b0, b1));
                @(negedge i_cam_pclk);
            end
            if (r == odd_row) begin
                i_cam_data = next_random_byte();  // orphan byte
                @(negedge i_cam_pclk);
            end
            i_cam_href = 1'b0;
            repeat (3) @(negedge i_cam_pclk);
        end
        repeat (4) @(negedge i_cam_pclk);  // pipeline flush
        expect_equal("o_vsync_posedge count", 1, pos_cnt - pos0);
        expect_equal("o_vsync_negedge count", 1, neg_cnt - neg0);
        expect_equal("o_sof count", captured ? 1 : 0, sof_cnt - sof0);
        expect_equal("o_buf_wr count", captured ? 24 : 0, wr_cnt - wr0);
        expect_equal("pending pixel pairs", 0, exp_q.size());
    endtask

    //------------------------------------------------------------
    // main sequence
    //------------------------------------------------------------
    initial begin
        i_cfg_clk   = 1'b0;
        i_cam_pclk  = 1'b0;
        i_rst_n     = 1'b0;
        i_cfg_init  = 1'b0;
        i_cam_vsync = 1'b0;
        i_cam_href  = 1'b0;
        i_cam_data  = 8'h00;
        repeat (10) begin
            @(negedge i_cfg_clk);
            check_idle_outputs();
        end
        i_rst_n = 1'b1;
        repeat (3) begin
            @(negedge i_cfg_clk);
            check_idle_outputs();
        end

        send_frame(1'b0, -1);  // config not done, no capture

        pulse_init(1'b1);
        repeat (2500) @(negedge i_cfg_clk);  // well into the third write
        pulse_init(1'b0);  // busy, ignored
        wait_cfg_done();
        expect_equal("sccb write count", 6, txn_cnt);

        repeat (10) @(negedge i_cam_pclk);  // done crosses to pclk
        send_frame(1'b1, -1);
        send_frame(1'b1, 2);

        pulse_init(1'b1);  // second load, stretched bit inside
        wait_cfg_done();
        expect_equal("sccb write count", 12, txn_cnt);
        assert (stretch_seen) else report_failure("slave never stretched SCL");
        repeat (10) @(negedge i_cam_pclk);
        send_frame(1'b1, 1);

        $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
